// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := uart_cmd_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@! grep -q "=== FAIL ===" $(LOG) && grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/uart_cmd_fsm.sv ====
`default_nettype none

module uart_cmd_fsm (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_pkg::uart_cmd_t cmd_in,
  input  wire logic                cmd_vld,
  input  wire logic                tx_done,
  input  wire logic                rx_vld,
  input  wire logic [7:0]          rx_byte,
  input  wire logic                rx_parity_err,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output logic [7:0]               tx_byte,
  output logic                     read_rdy,
  output uart_pkg::read_rsp_t      read_data
);

  import uart_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,   // Upper byte on the line
    S_GAP,
    S_DATA,   // Lower byte of a write
    S_WAIT,   // Read answer or timeout
    S_RESP
  } seq_state_t;

  seq_state_t            state;
  uart_cmd_t             cmd_q;
  logic [WAIT_CNT_W-1:0] wait_cnt;   // Gap and timeout share it
  logic                  accept;
  logic                  gap_end;
  logic                  timeout;

  assign cmd_rdy  = state == S_IDLE;
  assign read_rdy = state == S_RESP;
  assign accept   = cmd_vld && cmd_rdy;
  assign gap_end  = wait_cnt == WAIT_CNT_W'(GAP_CYCLES - 1);
  assign timeout  = wait_cnt == WAIT_CNT_W'(RESP_TIMEOUT - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      wait_cnt <= '0;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (accept)
          begin
            tx_start <= 1'b1;   // Start bit on the following edge
            state    <= S_ADDR;
          end
        end
        S_ADDR:
        begin
          if (tx_done)
          begin
            wait_cnt <= '0;
            state    <= cmd_q.write ? S_GAP : S_WAIT;
          end
        end
        S_GAP:
        begin
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= S_DATA;
          end
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        S_DATA:
        begin
          if (tx_done)
            state <= S_IDLE;
        end
        S_WAIT:
        begin
          if (rx_vld || timeout)
            state <= S_RESP;
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        S_RESP:
          state <= S_IDLE;   // One-cycle read_rdy
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Command, outgoing byte and answer
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= {cmd_in.write, cmd_in.addr};
    end
    if (state == S_GAP && gap_end)
      tx_byte <= cmd_q.data;
    if (state == S_WAIT)
    begin
      if (rx_vld)
        read_data <= '{data: rx_byte, parity_err: rx_parity_err, timeout: 1'b0};
      else if (timeout)
        read_data <= '{data: 8'h00, parity_err: 1'b0, timeout: 1'b1};
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_cmd_top.sv ====
`default_nettype none

module uart_cmd_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire uart_pkg::uart_cmd_t cmd_in,
  input  wire logic                cmd_vld,
  output logic                     cmd_rdy,
  input  wire logic                rx,
  output logic                     tx,
  output logic                     read_rdy,
  output uart_pkg::read_rsp_t      read_data
);

  logic       tx_start;
  logic       tx_done;
  logic [7:0] tx_byte;
  logic       rx_vld;
  logic       rx_parity_err;
  logic [7:0] rx_byte;

  uart_cmd_fsm uart_cmd_fsm_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .tx_done       (tx_done),
    .rx_vld        (rx_vld),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .read_rdy      (read_rdy),
    .read_data     (read_data)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (),   // Sequencer tracks frames by tx_done
    .tx_done  (tx_done)
  );

  // Free running, sequencer filters the frames
  uart_rx uart_rx_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_vld        (rx_vld),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err)
  );

endmodule

`default_nettype wire

// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // Line timing, sim rate
  localparam int CLKS_PER_BIT = 8;
  localparam int FRAME_BITS   = 11;   // Start, 8 data, parity, stop
  localparam int GAP_CYCLES   = 16;
  localparam int RESP_TIMEOUT = 40 * CLKS_PER_BIT;

  // Counter widths
  localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);
  localparam int WAIT_CNT_W = $clog2(RESP_TIMEOUT);

  // Host command, upper byte goes out first
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  // Read answer returned to the host
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       timeout;   // No frame came back
  } read_rsp_t;

  // Even parity bit for one data byte
  function automatic logic even_parity(input logic [7:0] b);
    logic p;
    p = ^b;
    return p;
  endfunction

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
`default_nettype none

module uart_rx (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic rx,
  output logic       rx_vld,
  output logic [7:0] rx_byte,
  output logic       rx_parity_err
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,   // Waiting for start bit middle
    RX_BITS,    // Data, parity, stop
    RX_TAIL     // Half bit after stop sample
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [7:0]            data_q;
  logic                  par_q;
  logic                  half_bit;
  logic                  full_bit;

  assign half_bit = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);
  assign full_bit = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);
  assign rx_byte  = data_q;

  // Two-flop synchronizer plus one stage for the edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= RX_IDLE;
      baud_cnt      <= '0;
      bit_cnt       <= '0;
      rx_vld        <= 1'b0;
      rx_parity_err <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          if (rx_prev && !rx_sync)   // Falling edge
          begin
            baud_cnt <= '0;
            state    <= RX_START;
          end
        end
        RX_START:
        begin
          if (half_bit)
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_BITS;   // Glitch goes back
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_BITS:
        begin
          if (full_bit)
          begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 2))
            begin
              // Low stop bit also reported as parity error
              rx_parity_err <= (par_q != even_parity(data_q)) || !rx_sync;
              state         <= RX_TAIL;
            end
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_TAIL:
        begin
          if (half_bit)
          begin
            rx_vld <= 1'b1;
            state  <= RX_IDLE;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  // Sampled payload
  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && full_bit)
    begin
      if (bit_cnt < BIT_CNT_W'(8))
        data_q <= {rx_sync, data_q[7:1]};   // LSB first
      else if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 3))
        par_q <= rx_sync;
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       tx_start,
  input  wire logic [7:0] tx_byte,
  output logic            tx,
  output logic            tx_busy,
  output logic            tx_done
);

  import uart_pkg::*;

  logic [FRAME_BITS-1:0] shift_q;   // Bit 0 is on the line
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic                  bit_end;

  // Last cycle of the current bit
  assign bit_end = tx_busy && (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));

  // Last cycle of the stop bit
  assign tx_done = bit_end && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

  assign tx = shift_q[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q  <= '1;   // Line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        // Stop, parity, data LSB first, start
        shift_q  <= {1'b1, even_parity(tx_byte), tx_byte, 1'b0};
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx_busy  <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (tx_done)
      begin
        tx_busy <= 1'b0;   // Stop bit already high, stays on the line
      end
      else
      begin
        shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};   // Fill with idle ones
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verification/uart_cmd_tb.sv ====
`default_nettype none

module uart_cmd_tb;

  import uart_pkg::*;

  localparam int NUM_TESTS   = 10;
  localparam int TEST_CYCLES = 2 * FRAME_BITS * CLKS_PER_BIT + GAP_CYCLES
                               + RESP_TIMEOUT;
  localparam logic [1:0] ANS_NORMAL  = 2'd0;
  localparam logic [1:0] ANS_BAD_PAR = 2'd1;
  localparam logic [1:0] ANS_SILENT  = 2'd2;

  typedef struct packed {
    uart_cmd_t  cmd;
    logic [1:0] mode;
    logic       poke;   // Extra cmd_vld while busy
    read_rsp_t  exp;
  } entry_t;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_rdy;
  read_rsp_t  read_data;
  logic [1:0] mode;
  logic       frame_vld;
  logic [7:0] frame_byte;
  logic       frame_err;
  int         idle_cycles;
  entry_t     tbl [NUM_TESTS];
  logic [7:0] shadow [128];
  logic [7:0] frames [$];
  int         gaps [$];
  int         errors;
  int         frame_errors;
  int         rdy_pulses;

  uart_cmd_top uart_cmd_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  uart_line_model uart_line_model_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .mode        (mode),
    .rx          (rx),
    .frame_vld   (frame_vld),
    .frame_byte  (frame_byte),
    .frame_err   (frame_err),
    .idle_cycles (idle_cycles)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    #((NUM_TESTS + 2) * TEST_CYCLES * 4);
    $display("Watchdog expired, the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  // Frames seen on tx and read_rdy pulses
  always @(posedge clk)
  begin
    if (frame_vld)
    begin
      frames.push_back(frame_byte);
      gaps.push_back(idle_cycles);
      if (frame_err)
      begin
        frame_errors++;
        $display("Bad parity or stop bit in tx frame 0x%02h", frame_byte);
      end
    end
    if (read_rdy)
      rdy_pulses++;
  end

  function automatic uart_cmd_t make_cmd(input logic wr, input logic [6:0] addr,
                                         input logic [7:0] data);
    return '{wr, addr, data};
  endfunction

  task automatic report_mismatch(input string name, input int got, input int exp);
    errors++;
    $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  task automatic check_idle_outputs();
    if (tx !== 1'b1)
      report_mismatch("tx", tx, 1);
    if (cmd_rdy !== 1'b1)
      report_mismatch("cmd_rdy", cmd_rdy, 1);
    if (read_rdy !== 1'b0)
      report_mismatch("read_rdy", read_rdy, 0);
  endtask

  // Waits for cmd_rdy or read_rdy up to TEST_CYCLES
  task automatic wait_output(input logic for_read, output logic ok);
    int n;
    n  = 0;
    ok = for_read ? read_rdy : cmd_rdy;
    while (!ok && n < TEST_CYCLES)
    begin
      @(posedge clk);
      n++;
      ok = for_read ? read_rdy : cmd_rdy;
    end
  endtask

  task automatic run_entry(input entry_t e);
    int   base;
    int   pulses;
    logic ok;
    base   = frames.size();
    pulses = rdy_pulses;
    mode  <= e.mode;
    wait_output(1'b0, ok);
    if (!ok)
    begin
      errors++;
      $display("cmd_rdy stayed low, the DUT never became idle");
    end
    cmd_in  <= e.cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(posedge clk);
    if (e.poke)
    begin
      cmd_in  <= make_cmd(1'b0, 7'h33, 8'h00);   // Must be ignored
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    wait_output(!e.cmd.write, ok);
    if (!ok)
    begin
      errors++;
      $display("DUT did not finish the command in time");
    end
    else if (!e.cmd.write && read_data !== e.exp)
      report_mismatch("read_data", read_data, e.exp);
    @(posedge clk);
    if (rdy_pulses - pulses != int'(!e.cmd.write))
      report_mismatch("read_rdy pulses", rdy_pulses - pulses, !e.cmd.write);
    if (frames.size() - base != (e.cmd.write ? 2 : 1))
      report_mismatch("tx frame count", frames.size() - base, e.cmd.write ? 2 : 1);
    else
    begin
      if (frames[base] != {e.cmd.write, e.cmd.addr})
        report_mismatch("tx upper byte", frames[base], {e.cmd.write, e.cmd.addr});
      if (e.cmd.write && frames[base + 1] != e.cmd.data)
        report_mismatch("tx lower byte", frames[base + 1], e.cmd.data);
      if (e.cmd.write && gaps[base + 1] < GAP_CYCLES)
        report_mismatch("tx idle gap minimum", gaps[base + 1], GAP_CYCLES);
    end
  endtask

  initial
  begin
    int seed;
    int exp_frames;
    int exp_reads;
    seed       = 80;
    exp_frames = 0;
    exp_reads  = 0;
    errors     = 0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    mode       = ANS_NORMAL;
    for (int a = 0; a < 128; a++)
      shadow[a] = 8'($random(seed));
    tbl[0] = '{make_cmd(1'b1, 7'h05, 8'hA5), ANS_NORMAL, 1'b0, '0};
    tbl[1] = '{make_cmd(1'b0, 7'h05, 8'h00), ANS_NORMAL, 1'b0, '0};
    tbl[2] = '{make_cmd(1'b0, 7'h22, 8'h00), ANS_NORMAL, 1'b0, '0};
    tbl[3] = '{make_cmd(1'b0, 7'h22, 8'h00), ANS_BAD_PAR, 1'b0, '0};
    tbl[4] = '{make_cmd(1'b0, 7'h10, 8'h00), ANS_SILENT, 1'b0, '0};
    tbl[5] = '{make_cmd(1'b1, 7'h7F, 8'h3C), ANS_NORMAL, 1'b1, '0};
    tbl[6] = '{make_cmd(1'b0, 7'h7F, 8'h00), ANS_NORMAL, 1'b1, '0};
    tbl[7] = '{make_cmd(1'b1, 7'h22, 8'h00), ANS_NORMAL, 1'b0, '0};
    tbl[8] = '{make_cmd(1'b0, 7'h22, 8'h00), ANS_NORMAL, 1'b0, '0};
    tbl[9] = '{make_cmd(1'b0, 7'h05, 8'h00), ANS_BAD_PAR, 1'b0, '0};
    // Expected answers follow the writes in table order
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      if (tbl[i].cmd.write)
        shadow[tbl[i].cmd.addr] = tbl[i].cmd.data;
      else if (tbl[i].mode == ANS_SILENT)
        tbl[i].exp = '{data: 8'h00, parity_err: 1'b0, timeout: 1'b1};
      else
        tbl[i].exp = '{data: shadow[tbl[i].cmd.addr],
                       parity_err: tbl[i].mode == ANS_BAD_PAR, timeout: 1'b0};
      exp_frames += tbl[i].cmd.write ? 2 : 1;
      exp_reads  += tbl[i].cmd.write ? 0 : 1;
    end
    for (int c = 0; c < 8; c++)
    begin
      @(posedge clk);
      if (c > 0)
        check_idle_outputs();
    end
    rst_n <= 1'b1;
    repeat (2)
    begin
      @(posedge clk);
      check_idle_outputs();
    end
    for (int i = 0; i < NUM_TESTS; i++)
      run_entry(tbl[i]);
    repeat (2 * FRAME_BITS * CLKS_PER_BIT) @(posedge clk);   // Catch late frames
    if (frames.size() != exp_frames)
      report_mismatch("total tx frames", frames.size(), exp_frames);
    if (rdy_pulses != exp_reads)
      report_mismatch("total read_rdy pulses", rdy_pulses, exp_reads);
    $display("Errors: %0d failed checks, %0d bad tx frames", errors, frame_errors);
    if (errors == 0 && frame_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/uart_line_model.sv ====
`default_nettype none

module uart_line_model (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       tx,
  input  wire logic [1:0] mode,          // 0 normal, 1 flipped parity, 2 silent
  output logic            rx,
  output logic            frame_vld,
  output logic [7:0]      frame_byte,
  output logic            frame_err,     // Bad parity or stop bit
  output int              idle_cycles    // Idle tx cycles before this frame
);

  import uart_pkg::*;

  logic [7:0] mem [128];

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic recv_frame(output logic [7:0] b, output logic err);
    logic par;
    wait_clks(CLKS_PER_BIT / 2 - 1);   // Middle of start bit
    err = tx;
    for (int i = 0; i < 8; i++)
    begin
      wait_clks(CLKS_PER_BIT);
      b[i] = tx;
    end
    wait_clks(CLKS_PER_BIT);
    par = tx;
    wait_clks(CLKS_PER_BIT);
    err = err || (par != ^b) || !tx;
  endtask

  task automatic send_frame(input logic [7:0] b, input logic flip);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, (^b) ^ flip, b, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx <= bits[i];
      wait_clks(CLKS_PER_BIT);
    end
  endtask

  initial
  begin
    logic [7:0] b;
    logic       err;
    logic       armed;
    logic [6:0] wr_addr;
    int         high_cnt;
    int         seed;
    seed = 80;
    for (int a = 0; a < 128; a++)
      mem[a] = 8'($random(seed));
    rx        = 1'b1;
    frame_vld = 1'b0;
    armed     = 1'b0;
    wr_addr   = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    forever
    begin
      high_cnt = 0;
      while (tx !== 1'b0)
      begin
        high_cnt++;
        @(posedge clk);
      end
      recv_frame(b, err);
      frame_byte  <= b;
      frame_err   <= err;
      idle_cycles <= high_cnt - CLKS_PER_BIT / 2;   // Rest of the stop bit
      frame_vld   <= 1'b1;
      @(posedge clk);
      frame_vld <= 1'b0;
      if (armed)
      begin
        mem[wr_addr] = b;
        armed = 1'b0;
      end
      else if (b[7])
      begin
        armed   = 1'b1;
        wr_addr = b[6:0];
      end
      else if (mode != 2'd2)
      begin
        wait_clks(3 * CLKS_PER_BIT);
        send_frame(mem[b[6:0]], mode == 2'd1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_cmd_fsm.sv
logic/uart_cmd_top.sv
verification/uart_line_model.sv
verification/uart_cmd_tb.sv
